/* files.f */
rtl/sd_dac_pkg.sv
rtl/sd_dither_gen.sv
rtl/sd_interpolator.sv
rtl/sd_modulator.sv
rtl/sd2_dac.sv
verif/sd2_dac_checks.sv
verif/sd2_dac_tb.sv

/* run_sim.sh */
#!/bin/sh
# Verilator build and run of the sigma-delta DAC testbench
# The result is taken from the simulation log
rm -f sim.log \
  && verilator --binary --timing --assert -f files.f --top-module sd2_dac_tb \
       -Mdir obj_dir -o sd2_dac_sim \
  && ./obj_dir/sd2_dac_sim | tee sim.log \
  && grep -q "TEST PASSED" sim.log \
  && echo "simulation ok" \
  || { echo "simulation failed"; exit 1; }

/* verif/sd2_dac_tb.sv */
/* Testbench for the stereo sigma-delta DAC
   Measures pulse density per channel against the expected transfer rule */
`timescale 1ns/1ps

module sd2_dac_tb import sd_dac_pkg::*; ();

  localparam int  DW       = DEF_DW;
  localparam int  ID       = DEF_ID;
  localparam int  A1W      = DEF_A1W;
  localparam int  A2W      = DEF_A2W;
  localparam int  PERIOD   = 8;
  localparam int  FRAME    = 1 << ID;
  localparam int  SETTLE   = 3 * FRAME;
  localparam int  COUNT    = 4096;
  localparam int  IDLE_WIN = 64;
  localparam int  RST_CYC  = 5;
  localparam real TOL      = 0.02;
  localparam bit [31:0] SEED = 32'hf87c692a;

  // Reset, idle window, then six density phases
  localparam int PHASE_CYCLES = RST_CYC + 1 + SETTLE + IDLE_WIN + 6 * (SETTLE + COUNT);
  localparam int WATCHDOG_NS  = PHASE_CYCLES * PERIOD * 12 / 10;

  logic                 clk;
  logic                 reset;
  logic signed [DW-1:0] ldatasum;
  logic signed [DW-1:0] rdatasum;
  logic                 left;
  logic                 right;

  int check_fails;
  int idle_checks;
  int errors       = 0;
  int tests_run    = 0;
  int tests_failed = 0;
  // Posedges since reset release, equals the DUT frame position of the next edge
  int post_cycles  = 0;

  sd2_dac #(
    .DW  (DW),
    .ID  (ID),
    .A1W (A1W),
    .A2W (A2W)
  ) sd2_dac_i (
    .clk      (clk),
    .reset    (reset),
    .ldatasum (ldatasum),
    .rdatasum (rdatasum),
    .left     (left),
    .right    (right)
  );

  sd2_dac_checks #(
    .DW (DW),
    .ID (ID)
  ) checks_i (
    .clk         (clk),
    .reset       (reset),
    .ldatasum    (ldatasum),
    .rdatasum    (rdatasum),
    .left        (left),
    .right       (right),
    .fail_count  (check_fails),
    .idle_checks (idle_checks)
  );

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  always @(posedge clk) begin
    if (reset) begin
      post_cycles <= 0;
    end else begin
      post_cycles <= post_cycles + 1;
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired before all tests finished");
    $display("TEST FAILED");
    $finish;
  end

  // Fraction of ones for a held sample, gain of three over the rail span
  function automatic real expected_density(input int x);
    return 0.5 + 3.0 * real'(x) / real'(1 << (DW + 2));
  endfunction

  function automatic int pick(input int lo, input int hi);
    return lo + int'($urandom % (hi - lo + 1));
  endfunction

  function automatic int total_errors();
    return errors + check_fails;
  endfunction

  // Holds both inputs, settles three frames, then counts ones
  // With glitch set, left carries gval in the middle of every frame
  task automatic run_phase(input int lval, input int rval, input bit glitch, input int gval,
                           output real lden, output real rden);
    int lones;
    int rones;
    int pos;
    lones = 0;
    rones = 0;
    for (int i = 0; i < SETTLE + COUNT; i++) begin
      @(negedge clk);
      pos = post_cycles % FRAME;
      if (glitch && pos >= FRAME / 4 && pos < 3 * FRAME / 4) begin
        ldatasum = DW'(gval);
      end else begin
        ldatasum = DW'(lval);
      end
      rdatasum = DW'(rval);
      if (i >= SETTLE) begin
        if (left) lones++;
        if (right) rones++;
      end
    end
    lden = real'(lones) / real'(COUNT);
    rden = real'(rones) / real'(COUNT);
  endtask

  task automatic check_density(input string sig, input int sample, input real actual);
    real expected;
    real diff;
    expected = expected_density(sample);
    diff = actual - expected;
    if (diff < 0.0) diff = -diff;
    assert (diff <= TOL) else begin
      $display("CHECK FAILED t=%0t %s density expected %0.4f actual %0.4f",
               $time, sig, expected, actual);
      errors++;
    end
  endtask

  task automatic finish_test(input string name, input int errs_before);
    tests_run++;
    if (total_errors() == errs_before) begin
      $display("test %0d %s: ok", tests_run, name);
    end else begin
      $display("test %0d %s: failed", tests_run, name);
      tests_failed++;
    end
  endtask

  initial begin
    int  errs;
    int  lv;
    int  rv;
    int  gv;
    int  lvl [3];
    real dens [3];
    real ld;
    real rd;

    void'($urandom(SEED));
    reset    = 1'b1;
    ldatasum = '0;
    rdatasum = '0;
    repeat (RST_CYC) @(negedge clk);
    reset = 1'b0;

    // Reset level, checked by the port checker up to the first free cycle
    @(negedge clk);
    finish_test("reset level", 0);

    // Idle toggle on both channels
    errs = total_errors();
    repeat (SETTLE + IDLE_WIN) @(negedge clk);
    assert (idle_checks >= IDLE_WIN) else begin
      $display("Idle toggle was checked on only %0d cycles", idle_checks);
      errors++;
    end
    finish_test("idle toggle", errs);

    // Full-scale DC
    errs = total_errors();
    run_phase(32767, -32768, 1'b0, 0, ld, rd);
    check_density("left", 32767, ld);
    check_density("right", -32768, rd);
    finish_test("dc extremes", errs);

    // Different values per channel
    errs = total_errors();
    lv = pick(1000, 25000);
    rv = pick(-25000, -1000);
    run_phase(lv, rv, 1'b0, 0, ld, rd);
    check_density("left", lv, ld);
    check_density("right", rv, rd);
    finish_test("channel independence", errs);

    // Three levels from separated bands so densities differ clearly
    errs = total_errors();
    lvl[0] = pick(-30000, -20000);
    lvl[1] = pick(-5000, 5000);
    lvl[2] = pick(20000, 30000);
    rv = pick(-10000, 10000);
    for (int k = 0; k < 3; k++) begin
      run_phase(lvl[k], rv, 1'b0, 0, dens[k], rd);
      check_density("left", lvl[k], dens[k]);
    end
    for (int k = 1; k < 3; k++) begin
      assert (dens[k] > dens[k-1]) else begin
        $display("Left density did not increase from level %0d to level %0d", k - 1, k);
        errors++;
      end
    end
    finish_test("monotonic response", errs);

    // Mid-frame changes must be ignored
    errs = total_errors();
    lv = pick(-20000, -10000);
    gv = pick(20000, 30000);
    rv = pick(1000, 20000);
    run_phase(lv, rv, 1'b1, gv, ld, rd);
    check_density("left", lv, ld);
    finish_test("frame sampling", errs);

    $display("summary: %0d tests, %0d failed, %0d check errors",
             tests_run, tests_failed, total_errors());
    if (tests_failed == 0 && total_errors() == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

/* verif/sd2_dac_checks.sv */
/* Port-level checker for the stereo sigma-delta DAC
   Reset level, idle-channel toggling and output sanity */
`timescale 1ns/1ps

module sd2_dac_checks import sd_dac_pkg::*; #(
  parameter int DW = DEF_DW,
  parameter int ID = DEF_ID
) (
  input  logic                 clk,
  input  logic                 reset,
  input  logic signed [DW-1:0] ldatasum,
  input  logic signed [DW-1:0] rdatasum,
  input  logic                 left,
  input  logic                 right,
  output int                   fail_count,
  output int                   idle_checks
);

  // Zero input reaches the outputs well within three frames
  localparam int SETTLE = 3 * (1 << ID);

  logic reset_d  = 1'b0;
  logic left_q   = 1'b0;
  logic right_q  = 1'b0;
  int   zero_cnt = 0;
  int   fails    = 0;
  int   idles    = 0;

  assign fail_count  = fails;
  assign idle_checks = idles;

  always @(posedge clk) begin
    reset_d <= reset;
    left_q  <= left;
    right_q <= right;

    // Covers every reset cycle after the first and the cycle right after release
    if (reset_d) begin
      assert (left == 1'b0) else begin
        $display("CHECK FAILED t=%0t left expected 0 actual %b", $time, left);
        fails = fails + 1;
      end
      assert (right == 1'b0) else begin
        $display("CHECK FAILED t=%0t right expected 0 actual %b", $time, right);
        fails = fails + 1;
      end
    end

    // Outputs must be clean once out of reset
    if (!reset && !reset_d) begin
      assert (!$isunknown({left, right})) else begin
        $display("Output left or right is unknown at t=%0t", $time);
        fails = fails + 1;
      end
    end

    // Idle channels toggle every cycle
    if (!reset && ldatasum == '0 && rdatasum == '0) begin
      if (zero_cnt >= SETTLE) begin
        idles = idles + 1;
        assert (left != left_q) else begin
          $display("CHECK FAILED t=%0t left expected %b actual %b", $time, ~left_q, left);
          fails = fails + 1;
        end
        assert (right != right_q) else begin
          $display("CHECK FAILED t=%0t right expected %b actual %b", $time, ~right_q, right);
          fails = fails + 1;
        end
      end else begin
        zero_cnt = zero_cnt + 1;
      end
    end else begin
      zero_cnt = 0;
    end
  end

endmodule

/* rtl/sd2_dac.sv */
/* Stereo second-order sigma-delta audio DAC
   Shared dither source, per-channel interpolator and modulator */
`timescale 1ns/1ps

module sd2_dac import sd_dac_pkg::*; #(
  parameter int DW  = DEF_DW,
  parameter int ID  = DEF_ID,
  parameter int A1W = DEF_A1W,
  parameter int A2W = DEF_A2W
) (
  input  logic                 clk,
  input  logic                 reset,
  input  logic signed [DW-1:0] ldatasum,
  input  logic signed [DW-1:0] rdatasum,
  output logic                 left,
  output logic                 right
);

  // High-pass dither, common to both channels
  logic [DITHER_W-1:0] dither;

  // Interpolated samples, one new value per clock
  logic signed [DW-1:0] ldata_int;
  logic signed [DW-1:0] rdata_int;

  sd_dither_gen dither_i (
    .clk    (clk),
    .reset  (reset),
    .dither (dither)
  );

  // Left channel
  // Frame counters of both interpolators start together at reset
  sd_interpolator #(
    .DW (DW),
    .ID (ID)
  ) linterp_i (
    .clk     (clk),
    .reset   (reset),
    .sample  (ldatasum),
    .int_out (ldata_int)
  );

  sd_modulator #(
    .DW  (DW),
    .A1W (A1W),
    .A2W (A2W)
  ) lmod_i (
    .clk     (clk),
    .reset   (reset),
    .int_out (ldata_int),
    .dither  (dither),
    .bit_out (left)
  );

  // Right channel
  sd_interpolator #(
    .DW (DW),
    .ID (ID)
  ) rinterp_i (
    .clk     (clk),
    .reset   (reset),
    .sample  (rdatasum),
    .int_out (rdata_int)
  );

  sd_modulator #(
    .DW  (DW),
    .A1W (A1W),
    .A2W (A2W)
  ) rmod_i (
    .clk     (clk),
    .reset   (reset),
    .int_out (rdata_int),
    .dither  (dither),
    .bit_out (right)
  );

endmodule

/* rtl/sd_modulator.sv */
/* Second-order error-feedback sigma-delta modulator for one channel
   Gain of three, two integrators, dithered 1-bit quantizer */
`timescale 1ns/1ps

module sd_modulator import sd_dac_pkg::*; #(
  parameter int DW  = DEF_DW,
  parameter int A1W = DEF_A1W,
  parameter int A2W = DEF_A2W
) (
  input  logic                 clk,
  input  logic                 reset,
  input  logic signed [DW-1:0] int_out,
  input  logic [DITHER_W-1:0]  dither,
  output logic                 bit_out
);

  // Gained input and rail code width
  localparam int EW  = DW + 2;
  // First integrator width
  localparam int W1  = DW + A1W + 2;
  // Second integrator width
  localparam int W2  = DW + A2W + 2;
  // Quantizer input, one guard bit for the dither add
  localparam int QW  = DW + A2W + 3;
  // Dither bits taken from the top of the dither word
  localparam int DBW = 4;

  logic [EW-1:0]  gain;
  logic           gain_zero;
  logic [DBW-1:0] dith_top;
  logic [W1-1:0]  ac1;
  logic [W1-1:0]  aca1;
  logic [W2-1:0]  ac2;
  logic [W2-1:0]  aca2;
  logic [QW-1:0]  quant;
  logic [EW-1:0]  er;

  // x3 as (x << 1) + x, both terms sign-extended to EW bits
  assign gain = {int_out[DW-1], int_out, 1'b0} + {{2{int_out[DW-1]}}, int_out};

  // Idle channel detect
  assign gain_zero = (gain == '0);

  // Small dither, sign taken from the dither word MSB
  assign dith_top = dither[DITHER_W-1 -: DBW];

  // Quantizer input
  // Second integrator plus sign-extended dither
  assign quant = {ac2[W2-1], ac2} + {{(QW-DBW){dith_top[DBW-1]}}, dith_top};

  // Rail error codes
  // Negative quantizer value feeds back the most negative code
  // Otherwise the all-ones positive maximum
  always_comb begin
    if (quant[QW-1]) begin
      er = {1'b1, {(EW-1){1'b0}}};
    end else begin
      er = {1'b0, {(EW-1){1'b1}}};
    end
  end

  // First integrator next value
  // Input minus fed-back rail, both sign-extended
  assign aca1 = ac1 + {{A1W{gain[EW-1]}}, gain} - {{A1W{er[EW-1]}}, er};

  // Second integrator next value
  // Takes the new first-integrator value, so input reaches ac2 in one clock
  assign aca2 = ac2 + {{(A2W-A1W){aca1[W1-1]}}, aca1} - {{A2W{er[EW-1]}}, er};

  // Integrator registers
  always_ff @(posedge clk) begin
    if (reset) begin
      ac1 <= '0;
      ac2 <= '0;
    end else begin
      ac1 <= aca1;
      ac2 <= aca2;
    end
  end

  // Output bit
  // High when the positive rail was chosen
  // Zero input gives a steady toggle so no idle tone or DC appears
  always_ff @(posedge clk) begin
    if (reset) begin
      bit_out <= 1'b0;
    end else if (gain_zero) begin
      bit_out <= ~bit_out;
    end else begin
      bit_out <= ~er[EW-1];
    end
  end

endmodule

/* rtl/sd_interpolator.sv */
/* Linear interpolator for one DAC channel
   Captures a sample per frame and ramps to it in 2^ID equal steps */
`timescale 1ns/1ps

module sd_interpolator import sd_dac_pkg::*; #(
  parameter int DW = DEF_DW,
  parameter int ID = DEF_ID
) (
  input  logic                 clk,
  input  logic                 reset,
  input  logic signed [DW-1:0] sample,
  output logic signed [DW-1:0] int_out
);

  // Frame position
  logic [ID-1:0]    cnt;
  logic             frame_start;

  // Captured samples, newest and one frame older
  logic [DW-1:0]    cur;
  logic [DW-1:0]    prev;

  // Per-clock increment, one extra bit for the full difference range
  logic [DW:0]      step;

  // Ramp value with ID fraction bits
  logic [DW+ID-1:0] acc;

  // Counter wraps every 2^ID clocks
  always_ff @(posedge clk) begin
    if (reset) begin
      cnt <= '0;
    end else begin
      cnt <= cnt + 1'b1;
    end
  end

  // Input only looked at here
  assign frame_start = (cnt == '0);

  // Sample capture at frame start
  always_ff @(posedge clk) begin
    if (reset) begin
      cur  <= '0;
      prev <= '0;
    end else if (frame_start) begin
      prev <= cur;
      cur  <= sample;
    end
  end

  // Difference of the two captured samples
  // Divided by 2^ID implicitly through the fraction bits of acc
  assign step = {cur[DW-1], cur} - {prev[DW-1], prev};

  // Ramp accumulator
  always_ff @(posedge clk) begin
    if (reset) begin
      acc <= '0;
    end else if (frame_start) begin
      // Restart from the sample being ramped away from
      acc <= {cur, {ID{1'b0}}};
    end else begin
      // Sign-extended step, one 2^ID-th of the difference
      acc <= acc + {{(ID-1){step[DW]}}, step};
    end
  end

  // Integer part of the ramp
  // Reaches the new sample exactly at the following frame start
  assign int_out = acc[DW+ID-1:ID];

endmodule

/* rtl/sd_dither_gen.sv */
/* Dither source shared by both DAC channels
   Two XNOR LFSRs summed, then first-differenced into high-pass noise */
`timescale 1ns/1ps

module sd_dither_gen import sd_dac_pkg::*; (
  input  logic                clk,
  input  logic                reset,
  output logic [DITHER_W-1:0] dither
);

  // Sum of the reload values, so dither starts at zero after reset
  localparam logic [DITHER_W-1:0] SUM_RELOAD =
    DITHER_W'(SEED1_RELOAD) + DITHER_W'(SEED2_RELOAD);

  logic [SEED1_W-1:0]  seed1;
  logic [SEED2_W-1:0]  seed2;
  logic                fb1;
  logic                fb2;
  logic [DITHER_W-1:0] seed_sum;
  logic [DITHER_W-1:0] seed_prev;

  // XNOR feedback over the tapped bits
  assign fb1 = ~^(seed1 & SEED1_TAPS);
  assign fb2 = ~^(seed2 & SEED2_TAPS);

  // First LFSR
  always_ff @(posedge clk) begin
    if (reset) begin
      seed1 <= SEED1_RELOAD;
    end else if (&seed1) begin
      // Escape the lock-up state
      seed1 <= SEED1_RELOAD;
    end else begin
      seed1 <= {seed1[SEED1_W-2:0], fb1};
    end
  end

  // Second LFSR
  always_ff @(posedge clk) begin
    if (reset) begin
      seed2 <= SEED2_RELOAD;
    end else if (&seed2) begin
      seed2 <= SEED2_RELOAD;
    end else begin
      seed2 <= {seed2[SEED2_W-2:0], fb2};
    end
  end

  // Both sequences added, shorter one zero-extended
  assign seed_sum = DITHER_W'(seed1) + DITHER_W'(seed2);

  // Last cycle's sum
  always_ff @(posedge clk) begin
    if (reset) begin
      seed_prev <= SUM_RELOAD;
    end else begin
      seed_prev <= seed_sum;
    end
  end

  // First difference, removes DC from the noise
  // Wraps modulo 2^DITHER_W, read as two's complement downstream
  assign dither = seed_sum - seed_prev;

endmodule

/* rtl/sd_dac_pkg.sv */
/* Shared constants for the stereo sigma-delta DAC
   Dither LFSR setup and default datapath widths */
package sd_dac_pkg;

  // Dither sources
  // Two XNOR LFSRs of unrelated lengths, summed
  // Widths picked so the combined period is very long

  // First LFSR width
  localparam int SEED1_W = 24;

  // Second LFSR width
  localparam int SEED2_W = 19;

  // Loaded on reset and whenever the register reaches all ones
  // All ones is the lock-up state of an XNOR LFSR
  localparam logic [SEED1_W-1:0] SEED1_RELOAD = 24'h654321;
  localparam logic [SEED2_W-1:0] SEED2_RELOAD = 19'h12345;

  // Feedback taps as bit masks
  // Feedback bit is the XNOR of all masked bits

  // Taps at bits 23, 22, 21, 16
  localparam logic [SEED1_W-1:0] SEED1_TAPS = 24'he10000;

  // Taps at bits 18, 17, 16, 13, 0
  localparam logic [SEED2_W-1:0] SEED2_TAPS = 19'h72001;

  // Dither word carried to both modulators
  // Same width as the wider LFSR so the sum wraps cleanly
  localparam int DITHER_W = 24;

  // Default module parameters
  // Overridden only from the top level

  // PCM sample width
  localparam int DEF_DW = 16;

  // log2 of the interpolation ratio, frame is 2^ID clocks
  localparam int DEF_ID = 4;

  // Headroom bits of the first integrator
  localparam int DEF_A1W = 2;

  // Headroom bits of the second integrator
  // Must exceed DEF_A1W
  localparam int DEF_A2W = 5;

endpackage
